// ==== verilog/dmm_ctl_pkg.sv ====
// shared widths, register map, output modes and sequencer states
package dmm_ctl_pkg;

  //////////////////////////////////////////////////
  // widths

  localparam int CNT_W          = 24;   // count registers and spi data field
  localparam int SPI_FRAME_BITS = 32;
  localparam int SPI_CMD_BITS   = 8;    // write flag + 7 bit address
  localparam int SPI_BIT_CNT_W  = 6;    // saturating, so long frames stay distinguishable
  localparam int ADDR_W         = 7;
  localparam int NUM_SLOTS      = 4;
  localparam int SEQ_N_W        = $clog2(NUM_SLOTS) + 1;   // holds 0..4
  localparam int NUM_RW_REGS    = 9;    // addresses 0..8
  localparam int REG_IDX_W      = $clog2(NUM_RW_REGS);
  localparam int HW_FLAGS_W     = 4;

  // board output fields
  localparam int LED_W = 4;
  localparam int MON_W = 8;
  localparam int PC_W  = 2;   // precharge switches
  localparam int AZ_W  = 4;   // auto-zero mux
  // leds, monitor, pc_sw, azmux, meas_complete from bit 0 up
  localparam int OUT_W = LED_W + MON_W + PC_W + AZ_W + 1;

  localparam logic [7:0] STATUS_MAGIC = 8'b10101010;

  typedef logic [CNT_W-1:0]     count_t;
  typedef logic [1:0]           slot_idx_t;
  typedef logic [PC_W+AZ_W-1:0] slot_cfg_t;   // {pc_sw, azmux}

  //////////////////////////////////////////////////
  // register map

  typedef enum logic [ADDR_W-1:0] {
    REG_MODE      = 7'd0,
    REG_DIRECT    = 7'd1,
    REG_SEQ_N     = 7'd2,
    REG_SEQ0      = 7'd3,
    REG_SEQ1      = 7'd4,
    REG_SEQ2      = 7'd5,
    REG_SEQ3      = 7'd6,
    REG_PRECHARGE = 7'd7,
    REG_APERTURE  = 7'd8,
    REG_STATUS    = 7'd9    // read only
  } reg_addr_e;

  // other codes select all-low outputs
  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_PATTERN = 3'd3,
    MODE_SEQ     = 3'd6
  } mode_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_PRECHARGE,
    SEQ_MEASURE
  } seq_state_e;

endpackage

// ==== verilog/acq_cfg_if.sv ====
// acquisition configuration interface, register bank to sequencer and adc mock
`timescale 1ns/1ps

interface acq_cfg_if;
  import dmm_ctl_pkg::*;

  count_t                    seq_n;       // raw register, clamped by the sequencer
  slot_cfg_t [NUM_SLOTS-1:0] seq_slot;    // per slot {pc_sw, azmux}
  count_t                    precharge;   // clk cycles
  count_t                    aperture;    // clk cycles

  // static register contents, no handshake

  modport bank (
    output seq_n,
    output seq_slot,
    output precharge,
    output aperture
  );

  modport seq (
    input seq_n,
    input seq_slot,
    input precharge
  );

  modport adc (
    input aperture
  );

endinterface

// ==== verilog/acq_out_if.sv ====
// sequencer board-control outputs interface, to the mode selector
`timescale 1ns/1ps

interface acq_out_if;
  import dmm_ctl_pkg::*;

  logic [PC_W-1:0]  pc_sw;
  logic [AZ_W-1:0]  azmux;
  logic [LED_W-1:0] leds;
  logic [MON_W-1:0] monitor;
  logic             meas_complete;   // one cycle per finished slot

  modport src (
    output pc_sw,
    output azmux,
    output leds,
    output monitor,
    output meas_complete
  );

  modport sink (
    input pc_sw,
    input azmux,
    input leds,
    input monitor,
    input meas_complete
  );

endinterface

// ==== verilog/spi_register_bank.sv ====
// spi slave, pin synchronizers, frame decode, config registers and status readback
`timescale 1ns/1ps

module spi_register_bank (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic                                 spi_sck_i,
  input  logic                                 spi_cs_n_i,
  input  logic                                 spi_mosi_i,
  input  logic [dmm_ctl_pkg::HW_FLAGS_W-1:0]   hw_flags_i,
  input  dmm_ctl_pkg::slot_idx_t               sample_idx_last_i,
  output logic                                 spi_miso_o,
  output dmm_ctl_pkg::mode_e                   mode_o,
  output logic [dmm_ctl_pkg::OUT_W-1:0]        direct_o,
  acq_cfg_if.bank                              cfg
);
  import dmm_ctl_pkg::*;

  logic [2:0]                pin_meta;    // {sck, cs_n, mosi}
  logic [2:0]                pin_sync;
  logic                      sck_d;
  logic                      cs_n_d;      // also marks frame idle
  logic                      mosi_d;      // aligned with sck_rise
  logic                      sck_rise;
  logic                      sck_fall;
  logic                      cs_rise;
  logic [SPI_BIT_CNT_W-1:0]  bit_cnt;
  logic [SPI_FRAME_BITS-1:0] shift_in;
  count_t                    shift_out;
  logic                      miso_q;
  count_t                    regs [NUM_RW_REGS];
  logic [SPI_CMD_BITS-1:0]   cmd_byte;
  logic [ADDR_W-1:0]         rd_addr;
  count_t                    rd_data;
  count_t                    status_word;
  logic                      wr_flag;
  logic [ADDR_W-1:0]         wr_addr;
  count_t                    wr_data;

  //////////////////////////////////////////////////
  // pin sync and edge detect

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pin_meta <= 3'b010;   // cs_n idles high
      pin_sync <= 3'b010;
    end else begin
      pin_meta <= {spi_sck_i, spi_cs_n_i, spi_mosi_i};
      pin_sync <= pin_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_d    <= 1'b0;
      cs_n_d   <= 1'b1;
      mosi_d   <= 1'b0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      cs_rise  <= 1'b0;
    end else begin
      sck_d    <= pin_sync[2];
      cs_n_d   <= pin_sync[1];
      mosi_d   <= pin_sync[0];
      sck_rise <= pin_sync[2] & ~sck_d & ~pin_sync[1];   // only inside a frame
      sck_fall <= ~pin_sync[2] & sck_d & ~pin_sync[1];
      cs_rise  <= pin_sync[1] & ~cs_n_d;                 // end of frame
    end
  end

  //////////////////////////////////////////////////
  // shift in, bit count

  always_ff @(posedge clk) begin
    if (reset_i) begin
      bit_cnt <= '0;
    end else if (cs_n_d) begin
      bit_cnt <= '0;
    end else if (sck_rise) begin
      shift_in <= {shift_in[SPI_FRAME_BITS-2:0], mosi_d};   // msb first
      if (bit_cnt != '1) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // readback, command byte completes on the 8th rising edge
  assign cmd_byte    = {shift_in[SPI_CMD_BITS-2:0], mosi_d};
  assign rd_addr     = cmd_byte[ADDR_W-1:0];
  assign status_word = {6'b0, sample_idx_last_i, 4'b0, hw_flags_i, STATUS_MAGIC};

  always_comb begin
    rd_data = '0;   // unknown address reads zero
    if (rd_addr == REG_STATUS) begin
      rd_data = status_word;
    end else if (rd_addr < ADDR_W'(NUM_RW_REGS)) begin
      rd_data = regs[rd_addr[REG_IDX_W-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || cs_n_d) begin
      shift_out <= '0;
      miso_q    <= 1'b0;   // parked low between frames
    end else if (sck_rise && bit_cnt == SPI_BIT_CNT_W'(SPI_CMD_BITS - 1)) begin
      shift_out <= rd_data;
    end else if (sck_fall) begin
      miso_q    <= shift_out[CNT_W-1];
      shift_out <= {shift_out[CNT_W-2:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // write commit on cs_n rise, full frames only

  assign wr_flag = shift_in[SPI_FRAME_BITS-1];
  assign wr_addr = shift_in[SPI_FRAME_BITS-2 -: ADDR_W];
  assign wr_data = shift_in[CNT_W-1:0];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_RW_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (cs_rise && wr_flag && bit_cnt == SPI_BIT_CNT_W'(SPI_FRAME_BITS)) begin
      for (int i = 0; i < NUM_RW_REGS; i++) begin
        if (wr_addr == ADDR_W'(i)) begin
          regs[i] <= wr_data;   // status and unknown addresses fall through
        end
      end
    end
  end

  assign spi_miso_o    = miso_q;
  assign mode_o        = mode_e'(regs[REG_IDX_W'(REG_MODE)][$bits(mode_e)-1:0]);
  assign direct_o      = regs[REG_IDX_W'(REG_DIRECT)][OUT_W-1:0];
  assign cfg.seq_n     = regs[REG_IDX_W'(REG_SEQ_N)];
  assign cfg.seq_slot  = {regs[REG_IDX_W'(REG_SEQ3)][$bits(slot_cfg_t)-1:0],
                          regs[REG_IDX_W'(REG_SEQ2)][$bits(slot_cfg_t)-1:0],
                          regs[REG_IDX_W'(REG_SEQ1)][$bits(slot_cfg_t)-1:0],
                          regs[REG_IDX_W'(REG_SEQ0)][$bits(slot_cfg_t)-1:0]};
  assign cfg.precharge = regs[REG_IDX_W'(REG_PRECHARGE)];
  assign cfg.aperture  = regs[REG_IDX_W'(REG_APERTURE)];

endmodule

// ==== verilog/acquisition_sequencer.sv ====
// acquisition sequencer FSM, slot precharge/auto-zero control and adc handshake
`timescale 1ns/1ps

module acquisition_sequencer (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   trigger_i,
  input  logic                   adc_valid_i,
  output logic                   adc_run_o,
  output dmm_ctl_pkg::slot_idx_t sample_idx_last_o,
  acq_cfg_if.seq                 cfg,
  acq_out_if.src                 acq
);
  import dmm_ctl_pkg::*;

  seq_state_e         state;
  slot_idx_t          idx;         // slot in progress
  slot_idx_t          idx_next;
  slot_idx_t          idx_last;    // final slot before wrap
  slot_idx_t          last_q;      // last completed slot
  logic [SEQ_N_W-1:0] seq_n_eff;
  count_t             pc_cnt;
  slot_cfg_t          slot_q;      // drives switches and mux
  logic               run_q;
  logic               done;

  // clamp to the slot count
  always_comb begin
    if (cfg.seq_n > count_t'(NUM_SLOTS)) begin
      seq_n_eff = SEQ_N_W'(NUM_SLOTS);
    end else begin
      seq_n_eff = cfg.seq_n[SEQ_N_W-1:0];
    end
  end

  assign idx_last = slot_idx_t'(seq_n_eff - 1'b1);
  assign idx_next = (idx == idx_last) ? '0 : idx + 1'b1;   // wrap at seq_n
  assign done     = (state == SEQ_MEASURE) && adc_valid_i;

  //////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state  <= SEQ_IDLE;
      idx    <= '0;
      last_q <= '0;
      pc_cnt <= '0;
      slot_q <= '0;
      run_q  <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (trigger_i && seq_n_eff != '0) begin
            idx    <= '0;
            slot_q <= cfg.seq_slot[0];
            pc_cnt <= '0;
            state  <= SEQ_PRECHARGE;
          end
        end
        SEQ_PRECHARGE: begin
          if (pc_cnt >= cfg.precharge) begin
            run_q <= 1'b1;   // start adc
            state <= SEQ_MEASURE;
          end else begin
            pc_cnt <= pc_cnt + 1'b1;
          end
        end
        SEQ_MEASURE: begin
          if (adc_valid_i) begin
            run_q  <= 1'b0;
            last_q <= idx;
            // trigger checked only at the slot boundary
            if (trigger_i && seq_n_eff != '0) begin
              idx    <= idx_next;
              slot_q <= cfg.seq_slot[idx_next];   // next slot applied now
              pc_cnt <= '0;
              state  <= SEQ_PRECHARGE;
            end else begin
              state <= SEQ_IDLE;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  assign adc_run_o         = run_q;
  assign sample_idx_last_o = last_q;

  assign acq.pc_sw         = slot_q[AZ_W +: PC_W];
  assign acq.azmux         = slot_q[AZ_W-1:0];
  assign acq.meas_complete = done;   // registered by the mode mux
  assign acq.leds          = (state == SEQ_IDLE) ? '0 : LED_W'(1) << idx;   // one-hot slot
  assign acq.monitor       = {last_q, idx, adc_valid_i, run_q, state};

endmodule

// ==== verilog/adc_mock.sv ====
// mock adc, aperture counter with single-cycle valid
`timescale 1ns/1ps

module adc_mock (
  input  logic   clk,
  input  logic   reset_i,
  input  logic   adc_run_i,
  output logic   adc_valid_o,
  acq_cfg_if.adc cfg
);
  import dmm_ctl_pkg::*;

  count_t cnt;       // cycles with run high
  count_t ap_eff;
  logic   valid_q;

  assign ap_eff = (cfg.aperture == '0) ? CNT_W'(1) : cfg.aperture;   // 0 acts as 1

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt     <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= adc_run_i && (cnt == ap_eff);   // passes once per run
      if (!adc_run_i) begin
        cnt <= '0;
      end else if (cnt <= ap_eff) begin
        cnt <= cnt + 1'b1;   // stops one past the aperture
      end
    end
  end

  assign adc_valid_o = valid_q;

endmodule

// ==== verilog/output_mode_mux.sv ====
// output mode selector, test pattern counter and registered board outputs
`timescale 1ns/1ps

module output_mode_mux (
  input  logic                              clk,
  input  logic                              reset_i,
  input  dmm_ctl_pkg::mode_e                mode_i,
  input  logic [dmm_ctl_pkg::OUT_W-1:0]     direct_i,
  acq_out_if.sink                           acq,
  output logic [dmm_ctl_pkg::LED_W-1:0]     leds_o,
  output logic [dmm_ctl_pkg::MON_W-1:0]     monitor_o,
  output logic [dmm_ctl_pkg::PC_W-1:0]      pc_sw_o,
  output logic [dmm_ctl_pkg::AZ_W-1:0]      azmux_o,
  output logic                              meas_complete_o
);
  import dmm_ctl_pkg::*;

  logic [OUT_W-1:0] pat_cnt;    // free running
  logic [OUT_W-1:0] seq_vec;
  logic [OUT_W-1:0] sel_vec;
  logic [OUT_W-1:0] out_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pat_cnt <= '0;
    end else begin
      pat_cnt <= pat_cnt + 1'b1;
    end
  end

  // same field order as the direct register
  assign seq_vec = {acq.meas_complete, acq.azmux, acq.pc_sw, acq.monitor, acq.leds};

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  sel_vec = direct_i;
      MODE_PATTERN: sel_vec = pat_cnt;   // board bring-up
      MODE_SEQ:     sel_vec = seq_vec;
      default:      sel_vec = '0;        // unused modes, everything low
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_q <= '0;
    end else begin
      out_q <= sel_vec;
    end
  end

  //////////////////////////////////////////////////
  // unpack onto pins

  assign {meas_complete_o, azmux_o, pc_sw_o, monitor_o, leds_o} = out_q;

endmodule

// ==== verilog/dmm_ctl_top.sv ====
// acquisition board controller top, register bank, sequencer, adc mock and mode mux
`timescale 1ns/1ps

module dmm_ctl_top (
  input  logic                                clk,
  input  logic                                reset_i,

  // spi
  input  logic                                spi_sck_i,
  input  logic                                spi_cs_n_i,
  input  logic                                spi_mosi_i,
  output logic                                spi_miso_o,

  input  logic [dmm_ctl_pkg::HW_FLAGS_W-1:0]  hw_flags_i,
  input  logic                                trigger_i,

  // board outputs
  output logic [dmm_ctl_pkg::LED_W-1:0]       leds_o,
  output logic [dmm_ctl_pkg::MON_W-1:0]       monitor_o,
  output logic [dmm_ctl_pkg::PC_W-1:0]        pc_sw_o,
  output logic [dmm_ctl_pkg::AZ_W-1:0]        azmux_o,
  output logic                                meas_complete_o
);
  import dmm_ctl_pkg::*;

  mode_e            mode;
  logic [OUT_W-1:0] direct;
  slot_idx_t        sample_idx_last;
  logic             adc_run;
  logic             adc_valid;

  acq_cfg_if acq_cfg ();
  acq_out_if acq_out ();

  spi_register_bank u_regs (
    .clk               (clk),
    .reset_i           (reset_i),
    .spi_sck_i         (spi_sck_i),
    .spi_cs_n_i        (spi_cs_n_i),
    .spi_mosi_i        (spi_mosi_i),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .spi_miso_o        (spi_miso_o),
    .mode_o            (mode),
    .direct_o          (direct),
    .cfg               (acq_cfg.bank)
  );

  acquisition_sequencer u_seq (
    .clk               (clk),
    .reset_i           (reset_i),
    .trigger_i         (trigger_i),
    .adc_valid_i       (adc_valid),
    .adc_run_o         (adc_run),
    .sample_idx_last_o (sample_idx_last),
    .cfg               (acq_cfg.seq),
    .acq               (acq_out.src)
  );

  adc_mock u_adc (
    .clk         (clk),
    .reset_i     (reset_i),
    .adc_run_i   (adc_run),
    .adc_valid_o (adc_valid),
    .cfg         (acq_cfg.adc)
  );

  output_mode_mux u_mux (
    .clk             (clk),
    .reset_i         (reset_i),
    .mode_i          (mode),
    .direct_i        (direct),
    .acq             (acq_out.sink),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .pc_sw_o         (pc_sw_o),
    .azmux_o         (azmux_o),
    .meas_complete_o (meas_complete_o)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset generator, 8 ns period, reset for 5 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1 reset_o = 1'b0;   // released just after the 5th edge
  end

  always #4 clk_o = ~clk_o;

endmodule

// ==== test/dmm_ctl_tb.sv ====
// dmm_ctl testbench, spi host tasks, case-file reader, checks and timeout
`timescale 1ns/1ps

module dmm_ctl_tb;

  localparam logic [7:0] status_magic = 8'haa;

  logic       clk;
  logic       rst;
  logic       spi_sck_i;
  logic       spi_cs_n_i;
  logic       spi_mosi_i;
  logic       spi_miso_o;
  logic [3:0] hw_flags_i;
  logic       trigger_i;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic [3:0] azmux_o;
  logic       meas_complete_o;

  string       case_name [$];
  string       case_op [$];
  logic [7:0]  case_addr [$];
  logic [23:0] case_data [$];
  logic [23:0] shadow [0:8];   // expected register contents
  logic [15:0] lfsr;
  int          cycle_cnt;
  int          cycle_limit;    // 0 until the case file is read

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .reset_o (rst)
  );

  dmm_ctl_top dut (
    .clk             (clk),
    .reset_i         (rst),
    .spi_sck_i       (spi_sck_i),
    .spi_cs_n_i      (spi_cs_n_i),
    .spi_mosi_i      (spi_mosi_i),
    .spi_miso_o      (spi_miso_o),
    .hw_flags_i      (hw_flags_i),
    .trigger_i       (trigger_i),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .pc_sw_o         (pc_sw_o),
    .azmux_o         (azmux_o),
    .meas_complete_o (meas_complete_o)
  );

  //////////////////////////////////////////////////
  // helpers

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [23:0] expected,
                             input logic [23:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;   // inputs change just after the edge
  endtask

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_flags();
    for (int b = 0; b < 4; b++) begin
      lfsr          = lfsr_next(lfsr);   // one step per bit
      hw_flags_i[b] = lfsr[0];
    end
  endtask

  // one frame of nbits, msb first; miso sampled at the end of each low phase
  task automatic spi_frame(input logic [7:0] cmd, input logic [23:0] wdata,
                           input int nbits, output logic [23:0] rdata);
    logic [31:0] frame;
    frame      = {cmd, wdata};
    rdata      = '0;
    spi_cs_n_i = 1'b0;
    wait_cycles(5);
    for (int i = 31; i > 31 - nbits; i--) begin
      spi_mosi_i = frame[i];
      wait_cycles(5);                          // sck low phase
      if (i < 24) rdata[i] = spi_miso_o;
      spi_sck_i = 1'b1;
      wait_cycles(5);                          // sck high phase
      spi_sck_i = 1'b0;
    end
    wait_cycles(5);
    spi_cs_n_i = 1'b1;
    spi_mosi_i = 1'b0;
    wait_cycles(5);                            // write lands 4 cycles after cs rise
  endtask

  //////////////////////////////////////////////////
  // case operations

  task automatic check_pattern(input string name);
    logic [7:0] first;
    logic       moved;
    moved = 1'b0;
    @(negedge clk);
    first = monitor_o;
    for (int c = 0; c < 300 && !moved; c++) begin
      @(negedge clk);
      if (monitor_o !== first) moved = 1'b1;
    end
    if (!moved) stop_run({name, ": monitor output did not change in pattern mode"});
    wait_cycles(1);
  endtask

  task automatic run_sequence(input string name, input int count);
    int          n_eff;
    int          exp_idx;
    int          last_idx;
    int          seen;
    logic [23:0] rd;
    n_eff     = (shadow[2] > 24'd4) ? 4 : int'(shadow[2]);   // clamped slot count
    exp_idx   = 0;
    last_idx  = 0;
    seen      = 0;
    trigger_i = 1'b1;
    while (seen <= count) begin
      @(negedge clk);
      if (meas_complete_o) begin
        check_value(name, {18'b0, shadow[3 + exp_idx][5:0]}, {18'b0, pc_sw_o, azmux_o});
        check_value(name, 24'd1 << exp_idx, {20'b0, leds_o});   // slot order
        last_idx = exp_idx;
        exp_idx  = (exp_idx + 1) % n_eff;   // wraps at seq_n
        seen++;
        if (seen == count) begin
          @(posedge clk);
          #1 trigger_i = 1'b0;   // current slot still finishes
        end
      end
    end
    wait_cycles(5);
    draw_flags();
    spi_frame({1'b0, 7'd9}, 24'd0, 32, rd);
    check_value(name, {6'b0, 2'(last_idx), 4'b0, hw_flags_i, status_magic}, rd);
  endtask

  //////////////////////////////////////////////////
  // timeout

  always @(posedge clk) begin
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      stop_run("timeout, cycle limit reached");
    end else begin
      cycle_cnt = cycle_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // main

  initial begin
    int          fd;
    int          a;
    int          limit;
    string       line;
    string       name;
    string       op;
    logic [7:0]  addr_v;
    logic [23:0] data_v;
    logic [23:0] rd;
    logic [23:0] lim_shadow [0:8];

    spi_sck_i   = 1'b0;   // sck idles low
    spi_cs_n_i  = 1'b1;
    spi_mosi_i  = 1'b0;
    hw_flags_i  = 4'b0;
    trigger_i   = 1'b0;
    lfsr        = 16'd20;
    cycle_cnt   = 0;
    cycle_limit = 0;
    for (int i = 0; i < 9; i++) begin
      shadow[i]     = '0;
      lim_shadow[i] = '0;
    end

    fd = $fopen("test/dmm_ctl_cases.txt", "r");
    if (fd == 0) stop_run("cannot open test/dmm_ctl_cases.txt");
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments, blanks
        if ($sscanf(line, "%s %s %h %h", name, op, addr_v, data_v) != 4) begin
          stop_run({"malformed line in case file: ", line});
        end
        case_name.push_back(name);
        case_op.push_back(op);
        case_addr.push_back(addr_v);
        case_data.push_back(data_v);
      end
    end
    $fclose(fd);

    // 400 per case, plus slot time of each sequence incl. the trailing slot
    limit = 200;
    for (int k = 0; k < case_name.size(); k++) begin
      a     = int'(case_addr[k]);
      limit = limit + 400;
      if (case_op[k] == "W" && a < 9) lim_shadow[a] = case_data[k];
      if (case_op[k] == "S") begin
        limit = limit + (int'(case_data[k]) + 1) *
                (int'(lim_shadow[7]) + int'(lim_shadow[8]) + 1 + 10);
      end
    end
    cycle_limit = limit;

    wait (rst == 1'b0);
    wait_cycles(2);

    for (int k = 0; k < case_name.size(); k++) begin
      a = int'(case_addr[k]);
      if (case_op[k] == "W") begin
        spi_frame({1'b1, case_addr[k][6:0]}, case_data[k], 32, rd);
        if (a < 9) shadow[a] = case_data[k];   // status, unknown ignored
      end else if (case_op[k] == "A") begin
        spi_frame({1'b1, case_addr[k][6:0]}, case_data[k], 20, rd);   // cut short
      end else if (case_op[k] == "R") begin
        if (a == 9) draw_flags();
        spi_frame({1'b0, case_addr[k][6:0]}, 24'd0, 32, rd);
        if (a == 9) begin
          check_value(case_name[k], case_data[k] | {12'b0, hw_flags_i, 8'b0}, rd);
        end else begin
          check_value(case_name[k], case_data[k], rd);
        end
      end else if (case_op[k] == "O") begin
        wait_cycles(8);
        @(negedge clk);
        check_value(case_name[k], case_data[k],
                    {5'b0, meas_complete_o, azmux_o, pc_sw_o, monitor_o, leds_o});
        wait_cycles(1);
      end else if (case_op[k] == "P") begin
        check_pattern(case_name[k]);
      end else if (case_op[k] == "S") begin
        run_sequence(case_name[k], int'(case_data[k]));
      end else begin
        stop_run({"unknown operation in case ", case_name[k]});
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== dmm_ctl.f ====
verilog/dmm_ctl_pkg.sv
verilog/acq_cfg_if.sv
verilog/acq_out_if.sv
verilog/spi_register_bank.sv
verilog/acquisition_sequencer.sv
verilog/adc_mock.sv
verilog/output_mode_mux.sv
verilog/dmm_ctl_top.sv
test/tb_clock_gen.sv
test/dmm_ctl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dmm_ctl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f dmm_ctl.f --top-module dmm_ctl_tb -o dmm_ctl_sim

out=$(./obj_dir/dmm_ctl_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

// ==== test/dmm_ctl_cases.txt ====
# name op addr data, addr and data in hex
# W write, A aborted write, R read and compare, O outputs, P pattern, S sequence (data = completions)
rst_mode      R 00 000000
rst_direct    R 01 000000
rst_seq_n     R 02 000000
rst_seq0      R 03 000000
rst_seq1      R 04 000000
rst_seq2      R 05 000000
rst_seq3      R 06 000000
rst_prech     R 07 000000
rst_aper      R 08 000000
wr_direct     W 01 5a3c96
rd_direct     R 01 5a3c96
out_direct    O 00 023c96
wr_mode_bad   W 00 000005
out_bad       O 00 000000
wr_mode_pat   W 00 000003
pattern       P 00 000000
wr_prech      W 07 abcdef
rd_prech      R 07 abcdef
abort_prech   A 07 123456
rd_prech_kept R 07 abcdef
wr_status     W 09 ffffff
rd_status     R 09 0000aa
wr_unknown    W 20 777777
rd_unknown    R 20 000000
wr_seq_n      W 02 000003
wr_seq0       W 03 000015
wr_seq1       W 04 00002a
wr_seq2       W 05 000033
wr_seq3       W 06 00000c
wr_prech_seq  W 07 000006
wr_aper       W 08 000009
rd_aper       R 08 000009
wr_mode_seq   W 00 000006
seq_three     S 00 000007
wr_seq_n5     W 02 000005
wr_aper0      W 08 000000
seq_clamp     S 00 000006
